//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the video controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module video_controller_tb \
	--Mdir "$BUILD_DIR" -o video_controller_tb \
	-f video_controller.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/video_controller_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

//--- sim/video_controller_sva.sv
`timescale 1ns/1ps

module video_controller_sva #(
	parameter bit APB_PORT = 1'b1
) (
	input logic        i_clock,
	input logic        i_reset,
	input logic        i_psel,
	input logic        i_penable,
	input logic        i_pready,
	input logic        i_request,
	input logic [31:0] i_address,
	input logic        i_ready
);

	// Request and address hold until the memory takes the word
	request_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && !i_ready |=> i_request && $stable(i_address))
	else $error("Memory request or address changed before ready");

	if (APB_PORT) begin : g_apb
		pready_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
			i_pready |-> i_psel && i_penable)
		else $error("pready high outside an APB access phase");

		request_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
			i_request |-> i_psel && i_penable)
		else $error("Port A request outside an APB access phase");
	end

endmodule

bind video_apb_slave video_controller_sva #(.APB_PORT(1'b1)) u_apb_sva (
	.i_clock(i_clock), .i_reset(i_reset),
	.i_psel(i_psel), .i_penable(i_penable), .i_pready(o_pready),
	.i_request(o_vram_pa_request), .i_address(o_vram_pa_address),
	.i_ready(i_vram_pa_ready)
);

bind line_fetcher video_controller_sva #(.APB_PORT(1'b0)) u_fetch_sva (
	.i_clock(i_clock), .i_reset(i_reset),
	.i_psel(1'b0), .i_penable(1'b0), .i_pready(1'b0),
	.i_request(o_vram_pb_request), .i_address(o_vram_pb_address),
	.i_ready(i_vram_pb_ready)
);

//--- sim/video_controller_tb.sv
`timescale 1ns/1ps

module video_controller_tb;

	localparam int MAX_PITCH  = 640;
	localparam int VRAM_WORDS = 4096;
	localparam int FETCH_WAIT = 4000;

	logic        clock;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        pa_request;
	logic        pa_rw;
	logic [31:0] pa_address;
	logic [31:0] pa_wdata;
	logic [31:0] pa_rdata;
	logic        pa_ready;
	logic        pb_request;
	logic        pb_rw;
	logic [31:0] pb_address;
	logic [31:0] pb_wdata;
	logic [31:0] pb_rdata;
	logic        pb_ready;
	logic        hblank;
	logic        vblank;
	logic [10:0] pos_x;
	logic [23:0] rgb;

	// VRAM model and the testbench's own copies
	logic [31:0] vram_model [VRAM_WORDS];
	logic [31:0] vram_copy [VRAM_WORDS];
	logic [23:0] palette_copy [256];
	logic [31:0] pb_addresses [$];
	logic [31:0] offset_copy;
	logic [1:0]  mode_copy;
	logic [31:0] stim_seed;
	logic [31:0] model_seed;
	int          delay_a;
	int          delay_b;
	int          frame_total;

	// Pixel comparison pipeline
	logic        pos_valid;
	logic        stage1_valid;
	logic        stage2_valid;
	logic [10:0] stage1_x;
	logic [10:0] stage2_x;
	int          presented;
	int          checked;

	video_controller #(.MAX_PITCH(MAX_PITCH)) u_video_controller (
		.i_clock(clock), .i_reset(reset),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.o_vram_pa_request(pa_request), .o_vram_pa_rw(pa_rw),
		.o_vram_pa_address(pa_address), .o_vram_pa_wdata(pa_wdata),
		.i_vram_pa_rdata(pa_rdata), .i_vram_pa_ready(pa_ready),
		.o_vram_pb_request(pb_request), .o_vram_pb_rw(pb_rw),
		.o_vram_pb_address(pb_address), .o_vram_pb_wdata(pb_wdata),
		.i_vram_pb_rdata(pb_rdata), .i_vram_pb_ready(pb_ready),
		.i_video_hblank(hblank), .i_video_vblank(vblank),
		.i_video_pos_x(pos_x), .o_video_rgb(rgb)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	//================================================
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Odd multiplier, so every address bit shows up
	function automatic logic [31:0] fill_word(input int index);
		return (32'(index) * 32'h0101_0107) ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] region_address(input logic [3:0] region, input int offset);
		return {8'd0, region, 20'(offset)};
	endfunction

	// Pixel rule applied to the line fetched from row
	function automatic logic [23:0] expected_rgb(input int x, input logic [1:0] mode,
		input logic [31:0] row);
		int          word;
		int          byte_sel;
		logic [31:0] address;
		logic [31:0] data;
		logic [7:0]  colour;
		if (mode[video_regs_pkg::MODE_HDOUBLE]) begin
			word     = x / 8;
			byte_sel = (x / 2) % 4;
		end else begin
			word     = x / 4;
			byte_sel = x % 4;
		end
		address = row + 32'(4 * word);
		data    = vram_copy[address[13:2]];
		colour  = data[8 * byte_sel +: 8];
		return palette_copy[colour];
	endfunction

	task automatic fail_now(input string message);
		$display("%s", message);
		$display("SOME TESTS FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			fail_now($sformatf("** Error: %s is %h, expected %h", name, actual, expected));
		end
	endtask

	//================================================
	// APB master

	task automatic apb_transfer(input logic write, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = address;
		pwdata  = wdata;
		@(negedge clock);
		penable = 1'b1;
		cycles  = 0;
		while (!pready) begin
			@(negedge clock);
			cycles++;
			if (cycles > 20) begin
				fail_now("APB transfer saw no pready within 20 cycles");
			end
		end
		rdata = prdata;
		check_value("o_pslverr", {31'd0, pslverr}, 32'd0);
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] address, input logic [31:0] data);
		logic [31:0] unused;
		apb_transfer(1'b1, address, data, unused);
	endtask

	task automatic apb_read(input logic [31:0] address, output logic [31:0] data);
		apb_transfer(1'b0, address, 32'd0, data);
	endtask

	task automatic write_read_check(input logic [1:0] index, input logic [31:0] value);
		logic [31:0] data;
		apb_write(region_address(video_regs_pkg::REGION_CONTROL, 4 * int'(index)), value);
		apb_read(region_address(video_regs_pkg::REGION_CONTROL, 4 * int'(index)), data);
		check_value("o_prdata", data, value);
	endtask

	task automatic set_registers(input logic [31:0] offset, input logic [31:0] pitch,
		input logic [1:0] mode);
		apb_write(region_address(video_regs_pkg::REGION_CONTROL, 0), offset);
		apb_write(region_address(video_regs_pkg::REGION_CONTROL, 4), pitch);
		apb_write(region_address(video_regs_pkg::REGION_CONTROL, 8), {30'd0, mode});
		offset_copy = offset;
		mode_copy   = mode;
	endtask

	//================================================
	// Blanking and line fetch

	task automatic wait_fetch_done();
		int cycles;
		cycles = 0;
		while (!pb_request) begin
			@(negedge clock);
			cycles++;
			if (cycles > 10) begin
				fail_now("Port B request did not rise after the blanking edge");
			end
		end
		cycles = 0;
		while (pb_request) begin
			@(negedge clock);
			cycles++;
			if (cycles > FETCH_WAIT) begin
				fail_now("Port B fetch did not finish in time");
			end
		end
	endtask

	task automatic blank_pulse(input logic vertical, input logic expect_fetch);
		if (vertical) begin
			vblank = 1'b1;
			frame_total++;
		end else begin
			hblank = 1'b1;
		end
		if (expect_fetch) begin
			wait_fetch_done();
		end else begin
			repeat (4) begin
				@(negedge clock);
				assert (!pb_request) else begin
					fail_now("Port B started a fetch where none was expected");
				end
			end
		end
		@(negedge clock);
		vblank = 1'b0;
		hblank = 1'b0;
		// Edge history must see the low level
		repeat (2) @(negedge clock);
	endtask

	task automatic check_fetch(input logic [31:0] row, input int words);
		assert (pb_addresses.size() == words) else begin
			fail_now($sformatf("Port B fetched %0d words where %0d were expected",
				pb_addresses.size(), words));
		end
		for (int k = 0; k < words; k++) begin
			check_value("o_vram_pb_address", pb_addresses[k], row + 32'(4 * k));
		end
		pb_addresses.delete();
	endtask

	task automatic sweep_pixels(input int width);
		int cycles;
		for (int x = 0; x < width; x++) begin
			pos_x     = 11'(x);
			pos_valid = 1'b1;
			presented++;
			@(negedge clock);
		end
		pos_valid = 1'b0;
		cycles    = 0;
		while (checked < presented) begin
			@(negedge clock);
			cycles++;
			if (cycles > 10) begin
				fail_now("Pixel comparisons did not catch up with the sweep");
			end
		end
	endtask

	//================================================
	// VRAM model, both ports

	always @(negedge clock) begin
		if (reset) begin
			pa_ready <= 1'b0;
			pb_ready <= 1'b0;
		end else begin
			if (pa_request && delay_a == 0) begin
				pa_ready <= 1'b1;
				pa_rdata <= vram_model[pa_address[13:2]];
				if (pa_rw) begin
					vram_model[pa_address[13:2]] = pa_wdata;
				end
				model_seed = xorshift32(model_seed);
				delay_a    = int'(model_seed[1:0]);
			end else begin
				pa_ready <= 1'b0;
				if (pa_request) begin
					delay_a--;
				end
			end
			if (pb_request && delay_b == 0) begin
				// Port B only ever reads
				check_value("o_vram_pb_rw", {31'd0, pb_rw}, 32'd0);
				pb_ready <= 1'b1;
				pb_rdata <= vram_model[pb_address[13:2]];
				pb_addresses.push_back(pb_address);
				model_seed = xorshift32(model_seed);
				delay_b    = int'(model_seed[1:0]);
			end else begin
				pb_ready <= 1'b0;
				if (pb_request) begin
					delay_b--;
				end
			end
		end
	end

	//================================================
	// Pixel comparison

	always @(posedge clock) begin
		stage1_valid <= pos_valid;
		stage1_x     <= pos_x;
		stage2_valid <= stage1_valid;
		stage2_x     <= stage1_x;
	end

	// Output settled two edges after the position
	always @(negedge clock) begin
		if (stage2_valid) begin
			check_value("o_video_rgb", {8'd0, rgb},
				{8'd0, expected_rgb(int'(stage2_x), mode_copy, offset_copy)});
			checked++;
		end
	end

	//================================================
	// Test sequence

	initial begin
		logic [31:0] data;
		logic [31:0] addresses [16];
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = 32'd0;
		pwdata      = 32'd0;
		pa_rdata    = 32'd0;
		pa_ready    = 1'b0;
		pb_rdata    = 32'd0;
		pb_ready    = 1'b0;
		hblank      = 1'b0;
		vblank      = 1'b0;
		pos_x       = 11'd0;
		pos_valid   = 1'b0;
		presented   = 0;
		checked     = 0;
		frame_total = 0;
		delay_a     = 0;
		delay_b     = 0;
		offset_copy = 32'd0;
		mode_copy   = 2'd0;
		stim_seed   = 32'h2cda;
		model_seed  = 32'h2cda;
		for (int i = 0; i < VRAM_WORDS; i++) begin
			vram_model[i] = fill_word(i);
			vram_copy[i]  = fill_word(i);
		end
		repeat (5) @(negedge clock);
		reset = 1'b0;

		// Reset state
		check_value("o_pready", {31'd0, pready}, 32'd0);
		check_value("o_vram_pa_request", {31'd0, pa_request}, 32'd0);
		check_value("o_vram_pb_request", {31'd0, pb_request}, 32'd0);
		for (int r = 0; r < 4; r++) begin
			apb_read(region_address(video_regs_pkg::REGION_CONTROL, 4 * r), data);
			check_value("o_prdata", data, 32'd0);
		end

		// Frame counter, then register readback
		repeat (3) blank_pulse(1'b1, 1'b0);
		apb_read(region_address(video_regs_pkg::REGION_CONTROL,
			4 * int'(video_regs_pkg::REG_FRAME_COUNT)), data);
		check_value("o_prdata", data, 32'(frame_total));
		for (int n = 0; n < 4; n++) begin
			stim_seed = xorshift32(stim_seed);
			write_read_check(video_regs_pkg::REG_READ_OFFSET, stim_seed);
			stim_seed = xorshift32(stim_seed);
			write_read_check(video_regs_pkg::REG_PITCH, stim_seed);
			write_read_check(video_regs_pkg::REG_MODE, 32'(n));
		end

		// VRAM through port A
		for (int n = 0; n < 16; n++) begin
			stim_seed    = xorshift32(stim_seed);
			addresses[n] = {18'd0, stim_seed[11:0], 2'b00};
			stim_seed    = xorshift32(stim_seed);
			apb_write(addresses[n], stim_seed);
			vram_copy[addresses[n][13:2]] = stim_seed;
		end
		for (int n = 0; n < 16; n++) begin
			apb_read(addresses[n], data);
			check_value("o_prdata", data, vram_copy[addresses[n][13:2]]);
		end
		for (int i = 0; i < VRAM_WORDS; i++) begin
			check_value("vram_model", vram_model[i], vram_copy[i]);
		end

		// Fetch addresses, plain lines
		set_registers(32'h0000_0100, 32'd48, 2'b00);
		blank_pulse(1'b1, 1'b1);
		check_fetch(32'h0000_0100, 12);
		for (int line = 1; line <= 3; line++) begin
			blank_pulse(1'b0, 1'b1);
			check_fetch(32'h0000_0100 + 32'(48 * line), 12);
		end

		// Line doubling
		set_registers(32'h0000_0100, 32'd48, 2'(1 << video_regs_pkg::MODE_VDOUBLE));
		blank_pulse(1'b1, 1'b1);
		check_fetch(32'h0000_0100, 12);
		for (int line = 1; line <= 4; line++) begin
			blank_pulse(1'b0, (line % 2) == 0);
			if ((line % 2) == 0) begin
				check_fetch(32'h0000_0100 + 32'(48 * (line / 2)), 12);
			end
		end

		// Palette, then pixel sweeps
		for (int c = 0; c < 256; c++) begin
			stim_seed       = xorshift32(stim_seed);
			palette_copy[c] = stim_seed[23:0];
			apb_write(region_address(video_regs_pkg::REGION_PALETTE, 4 * c),
				{8'd0, stim_seed[23:0]});
		end
		apb_read(region_address(video_regs_pkg::REGION_PALETTE, 4), data);
		check_value("o_prdata", data, 32'd0);
		set_registers(32'h0000_0800, 32'd640, 2'b00);
		blank_pulse(1'b1, 1'b1);
		check_fetch(32'h0000_0800, MAX_PITCH / 4);
		sweep_pixels(640);
		set_registers(32'h0000_0800, 32'd640, 2'(1 << video_regs_pkg::MODE_HDOUBLE));
		sweep_pixels(640);

		apb_read(region_address(video_regs_pkg::REGION_CONTROL,
			4 * int'(video_regs_pkg::REG_FRAME_COUNT)), data);
		check_value("o_prdata", data, 32'(frame_total));

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- source/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256
) (
	input  logic                     i_clock,

	// Write port
	input  logic                     i_write,
	input  logic [$clog2(DEPTH)-1:0] i_write_index,
	input  logic [WIDTH-1:0]         i_write_data,

	// Read port, one cycle latency
	input  logic [$clog2(DEPTH)-1:0] i_read_index,
	output logic [WIDTH-1:0]         o_read_data
);

	logic [WIDTH-1:0] memory [DEPTH];

	always_ff @(posedge i_clock) begin
		if (i_write) begin
			memory[i_write_index] <= i_write_data;
		end
		// Old data on a read of the entry being written
		o_read_data <= memory[i_read_index];
	end

endmodule

//--- source/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher #(
	parameter int MAX_PITCH = 640
) (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_video_hblank,
	input  logic                              i_video_vblank,
	input  video_types_pkg::vram_addr_t       i_read_offset,
	input  video_types_pkg::vram_addr_t       i_pitch,
	input  logic [1:0]                        i_mode,

	// VRAM port B
	output logic                              o_vram_pb_request,
	output video_types_pkg::vram_addr_t       o_vram_pb_address,
	input  video_types_pkg::vram_word_t       i_vram_pb_rdata,
	input  logic                              i_vram_pb_ready,

	// Line buffer write
	output logic                              o_line_write,
	output logic [$clog2(MAX_PITCH/4)-1:0]    o_line_index,
	output video_types_pkg::vram_word_t       o_line_word,

	output logic [31:0]                       o_frame_count
);

	localparam int LINE_WORDS  = MAX_PITCH / 4;
	localparam int INDEX_WIDTH = $clog2(LINE_WORDS);
	localparam int COUNT_WIDTH = $clog2(LINE_WORDS + 1);

	typedef enum logic {
		IDLE,
		FETCH
	} state_t;

	state_t                      state;
	logic [1:0]                  hblank_history;
	logic [1:0]                  vblank_history;
	logic                        vblank_rise;
	logic                        hblank_rise;
	logic                        start_hblank;
	logic                        line_odd;
	video_types_pkg::vram_addr_t row;
	video_types_pkg::vram_addr_t next_row;
	video_types_pkg::vram_addr_t pitch_words;
	logic [COUNT_WIDTH-1:0]      line_words;
	logic [COUNT_WIDTH-1:0]      fetch_words;
	logic [COUNT_WIDTH-1:0]      word_count;
	logic                        word_accept;
	logic                        last_word;

	// Bit 1 holds the older sample
	assign vblank_rise  = (vblank_history == 2'b01);
	assign hblank_rise  = (hblank_history == 2'b01) && !vblank_history[0];
	assign start_hblank = hblank_rise && (!i_mode[video_regs_pkg::MODE_VDOUBLE] || line_odd);

	assign next_row    = row + i_pitch;
	assign pitch_words = i_pitch >> 2;
	// Never more words than the line buffer holds
	assign line_words  = (pitch_words > LINE_WORDS) ? COUNT_WIDTH'(LINE_WORDS)
	                                                : COUNT_WIDTH'(pitch_words);

	assign o_vram_pb_request = (state == FETCH);
	assign word_accept       = (state == FETCH) && i_vram_pb_ready;
	assign last_word         = (word_count == fetch_words - 1'b1);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= IDLE;
			hblank_history <= 2'b00;
			vblank_history <= 2'b00;
			line_odd       <= 1'b0;
			row            <= '0;
			fetch_words    <= '0;
			word_count     <= '0;
			o_line_write   <= 1'b0;
			o_frame_count  <= '0;
		end else begin
			hblank_history <= {hblank_history[0], i_video_hblank};
			vblank_history <= {vblank_history[0], i_video_vblank};
			o_line_write   <= word_accept;

			if (vblank_rise) begin
				o_frame_count <= o_frame_count + 1'b1;
				line_odd      <= 1'b0;
				row           <= i_read_offset;
			end else if (hblank_rise) begin
				line_odd <= !line_odd;
				if (start_hblank) begin
					row <= next_row;
				end
			end

			if ((vblank_rise || start_hblank) && (line_words != '0)) begin
				state       <= FETCH;
				fetch_words <= line_words;
				word_count  <= '0;
			end else if (word_accept) begin
				word_count <= word_count + 1'b1;
				if (last_word) begin
					state <= IDLE;
				end
			end
		end
	end

	//================================================
	// Address stepping and line buffer data

	always_ff @(posedge i_clock) begin
		if (vblank_rise) begin
			o_vram_pb_address <= i_read_offset;
		end else if (start_hblank) begin
			o_vram_pb_address <= next_row;
		end else if (word_accept) begin
			o_vram_pb_address <= o_vram_pb_address + 32'd4;
		end
		o_line_index <= word_count[INDEX_WIDTH-1:0];
		o_line_word  <= i_vram_pb_rdata;
	end

endmodule

//--- source/pixel_lookup.sv
`timescale 1ns/1ps

module pixel_lookup #(
	parameter int MAX_PITCH = 640
) (
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  video_types_pkg::pixel_pos_t    i_video_pos_x,
	input  logic [1:0]                     i_mode,

	// Line buffer read
	output logic [$clog2(MAX_PITCH/4)-1:0] o_line_index,
	input  video_types_pkg::vram_word_t    i_line_word,

	// Palette read
	output video_types_pkg::color_index_t  o_palette_index,
	input  video_types_pkg::rgb_t          i_palette_rgb,

	output video_types_pkg::rgb_t          o_video_rgb
);

	localparam int INDEX_WIDTH = $clog2(MAX_PITCH / 4);

	video_types_pkg::pixel_pos_t word_position;
	logic [1:0]                  byte_select;
	logic [1:0]                  byte_select_q;

	always_comb begin
		if (i_mode[video_regs_pkg::MODE_HDOUBLE]) begin
			word_position = i_video_pos_x >> 3;
			byte_select   = i_video_pos_x[2:1];
		end else begin
			word_position = i_video_pos_x >> 2;
			byte_select   = i_video_pos_x[1:0];
		end
	end

	assign o_line_index = INDEX_WIDTH'(word_position);

	// Lines up with the line buffer read data
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			byte_select_q <= 2'd0;
		end else begin
			byte_select_q <= byte_select;
		end
	end

	always_comb begin
		case (byte_select_q)
			2'd0:    o_palette_index = i_line_word[7:0];
			2'd1:    o_palette_index = i_line_word[15:8];
			2'd2:    o_palette_index = i_line_word[23:16];
			default: o_palette_index = i_line_word[31:24];
		endcase
	end

	// Palette output is already registered
	assign o_video_rgb = i_palette_rgb;

endmodule

//--- source/video_apb_slave.sv
`timescale 1ns/1ps

module video_apb_slave (
	input  logic                          i_clock,
	input  logic                          i_reset,

	// APB
	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [31:0]                   i_paddr,
	input  logic [31:0]                   i_pwdata,
	output logic [31:0]                   o_prdata,
	output logic                          o_pready,
	output logic                          o_pslverr,

	// VRAM port A
	output logic                          o_vram_pa_request,
	output logic                          o_vram_pa_rw,
	output video_types_pkg::vram_addr_t   o_vram_pa_address,
	output video_types_pkg::vram_word_t   o_vram_pa_wdata,
	input  video_types_pkg::vram_word_t   i_vram_pa_rdata,
	input  logic                          i_vram_pa_ready,

	// Palette write
	output logic                          o_palette_write,
	output video_types_pkg::color_index_t o_palette_index,
	output video_types_pkg::rgb_t         o_palette_rgb,

	// Control registers
	output video_types_pkg::vram_addr_t   o_read_offset,
	output video_types_pkg::vram_addr_t   o_pitch,
	output logic [1:0]                    o_mode,
	input  logic [31:0]                   i_frame_count
);

	typedef enum logic [1:0] {
		IDLE,
		VRAM_WAIT,
		COMPLETE
	} state_t;

	state_t                     state;
	video_regs_pkg::region_t    region;
	video_regs_pkg::reg_index_t reg_index;
	logic                       setup_phase;
	logic                       accept;
	logic [31:0]                reg_rdata;

	assign region      = i_paddr[23:20];
	assign reg_index   = i_paddr[3:2];
	assign setup_phase = i_psel && !i_penable;
	assign accept      = (state == IDLE) && setup_phase;
	assign o_pslverr   = 1'b0;

	always_comb begin
		case (reg_index)
			video_regs_pkg::REG_READ_OFFSET: reg_rdata = o_read_offset;
			video_regs_pkg::REG_PITCH:       reg_rdata = o_pitch;
			video_regs_pkg::REG_MODE:        reg_rdata = {30'd0, o_mode};
			default:                         reg_rdata = i_frame_count;
		endcase
	end

	//================================================
	// Transfer control

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state             <= IDLE;
			o_pready          <= 1'b0;
			o_vram_pa_request <= 1'b0;
			o_palette_write   <= 1'b0;
			o_read_offset     <= '0;
			o_pitch           <= '0;
			o_mode            <= '0;
		end else begin
			o_pready        <= 1'b0;
			o_palette_write <= 1'b0;
			case (state)
				IDLE: begin
					if (setup_phase) begin
						if (region == video_regs_pkg::REGION_CONTROL) begin
							if (i_pwrite) begin
								case (reg_index)
									video_regs_pkg::REG_READ_OFFSET: o_read_offset <= i_pwdata;
									video_regs_pkg::REG_PITCH:       o_pitch <= i_pwdata;
									video_regs_pkg::REG_MODE:        o_mode <= i_pwdata[1:0];
									default: ;
								endcase
							end
							o_pready <= 1'b1;
							state    <= COMPLETE;
						end else if (region == video_regs_pkg::REGION_PALETTE) begin
							o_palette_write <= i_pwrite;
							o_pready        <= 1'b1;
							state           <= COMPLETE;
						end else begin
							// Request is up in the first access cycle
							o_vram_pa_request <= 1'b1;
							state             <= VRAM_WAIT;
						end
					end
				end
				VRAM_WAIT: begin
					if (i_vram_pa_ready) begin
						o_vram_pa_request <= 1'b0;
						o_pready          <= 1'b1;
						state             <= COMPLETE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//================================================
	// Transfer data

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_vram_pa_rw      <= i_pwrite;
			o_vram_pa_address <= {8'd0, i_paddr[23:0]};
			o_vram_pa_wdata   <= i_pwdata;
			o_palette_index   <= i_paddr[9:2];
			o_palette_rgb     <= i_pwdata[23:0];
			// Palette reads give zero
			o_prdata <= (region == video_regs_pkg::REGION_CONTROL) ? reg_rdata : 32'd0;
		end else if ((state == VRAM_WAIT) && i_vram_pa_ready) begin
			o_prdata <= i_vram_pa_rdata;
		end
	end

endmodule

//--- source/video_controller.sv
`timescale 1ns/1ps

module video_controller #(
	parameter int MAX_PITCH = 640
) (
	input  logic                        i_clock,
	input  logic                        i_reset,

	// APB
	input  logic                        i_psel,
	input  logic                        i_penable,
	input  logic                        i_pwrite,
	input  logic [31:0]                 i_paddr,
	input  logic [31:0]                 i_pwdata,
	output logic [31:0]                 o_prdata,
	output logic                        o_pready,
	output logic                        o_pslverr,

	// VRAM port A
	output logic                        o_vram_pa_request,
	output logic                        o_vram_pa_rw,
	output video_types_pkg::vram_addr_t o_vram_pa_address,
	output video_types_pkg::vram_word_t o_vram_pa_wdata,
	input  video_types_pkg::vram_word_t i_vram_pa_rdata,
	input  logic                        i_vram_pa_ready,

	// VRAM port B
	output logic                        o_vram_pb_request,
	output logic                        o_vram_pb_rw,
	output video_types_pkg::vram_addr_t o_vram_pb_address,
	output video_types_pkg::vram_word_t o_vram_pb_wdata,
	input  video_types_pkg::vram_word_t i_vram_pb_rdata,
	input  logic                        i_vram_pb_ready,

	// Video
	input  logic                        i_video_hblank,
	input  logic                        i_video_vblank,
	input  video_types_pkg::pixel_pos_t i_video_pos_x,
	output video_types_pkg::rgb_t       o_video_rgb
);

	localparam int LINE_WORDS       = MAX_PITCH / 4;
	localparam int LINE_INDEX_WIDTH = $clog2(LINE_WORDS);

	logic                          palette_write;
	video_types_pkg::color_index_t palette_write_index;
	video_types_pkg::rgb_t         palette_write_rgb;
	video_types_pkg::color_index_t palette_read_index;
	video_types_pkg::rgb_t         palette_read_rgb;

	video_types_pkg::vram_addr_t   read_offset;
	video_types_pkg::vram_addr_t   pitch;
	logic [1:0]                    mode;
	logic [31:0]                   frame_count;

	logic                          line_write;
	logic [LINE_INDEX_WIDTH-1:0]   line_write_index;
	video_types_pkg::vram_word_t   line_write_word;
	logic [LINE_INDEX_WIDTH-1:0]   line_read_index;
	video_types_pkg::vram_word_t   line_read_word;

	// Port B only reads
	assign o_vram_pb_rw    = 1'b0;
	assign o_vram_pb_wdata = '0;

	video_apb_slave u_apb_slave (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.o_vram_pa_request(o_vram_pa_request), .o_vram_pa_rw(o_vram_pa_rw),
		.o_vram_pa_address(o_vram_pa_address), .o_vram_pa_wdata(o_vram_pa_wdata),
		.i_vram_pa_rdata(i_vram_pa_rdata), .i_vram_pa_ready(i_vram_pa_ready),
		.o_palette_write(palette_write), .o_palette_index(palette_write_index),
		.o_palette_rgb(palette_write_rgb),
		.o_read_offset(read_offset), .o_pitch(pitch), .o_mode(mode),
		.i_frame_count(frame_count)
	);

	line_fetcher #(.MAX_PITCH(MAX_PITCH)) u_line_fetcher (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_video_hblank(i_video_hblank), .i_video_vblank(i_video_vblank),
		.i_read_offset(read_offset), .i_pitch(pitch), .i_mode(mode),
		.o_vram_pb_request(o_vram_pb_request), .o_vram_pb_address(o_vram_pb_address),
		.i_vram_pb_rdata(i_vram_pb_rdata), .i_vram_pb_ready(i_vram_pb_ready),
		.o_line_write(line_write), .o_line_index(line_write_index),
		.o_line_word(line_write_word), .o_frame_count(frame_count)
	);

	pixel_lookup #(.MAX_PITCH(MAX_PITCH)) u_pixel_lookup (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_video_pos_x(i_video_pos_x), .i_mode(mode),
		.o_line_index(line_read_index), .i_line_word(line_read_word),
		.o_palette_index(palette_read_index), .i_palette_rgb(palette_read_rgb),
		.o_video_rgb(o_video_rgb)
	);

	//================================================
	// Memories

	dual_port_ram #(.WIDTH(24), .DEPTH(256)) u_palette (
		.i_clock(i_clock),
		.i_write(palette_write), .i_write_index(palette_write_index),
		.i_write_data(palette_write_rgb),
		.i_read_index(palette_read_index), .o_read_data(palette_read_rgb)
	);

	dual_port_ram #(.WIDTH(32), .DEPTH(LINE_WORDS)) u_line_buffer (
		.i_clock(i_clock),
		.i_write(line_write), .i_write_index(line_write_index),
		.i_write_data(line_write_word),
		.i_read_index(line_read_index), .o_read_data(line_read_word)
	);

endmodule

//--- source/video_regs_pkg.sv
package video_regs_pkg;

	// Region code from address bits 23:20
	typedef logic [3:0] region_t;

	localparam region_t REGION_PALETTE = 4'he;
	localparam region_t REGION_CONTROL = 4'hf;

	// Control register index from address bits 3:2
	typedef logic [1:0] reg_index_t;

	localparam reg_index_t REG_READ_OFFSET = 2'd0;
	localparam reg_index_t REG_PITCH       = 2'd1;
	localparam reg_index_t REG_MODE        = 2'd2;
	localparam reg_index_t REG_FRAME_COUNT = 2'd3;

	// Mode register bits
	localparam int MODE_HDOUBLE = 0;
	localparam int MODE_VDOUBLE = 1;

endpackage

//--- source/video_types_pkg.sv
package video_types_pkg;

	// Byte address into video memory
	typedef logic [31:0] vram_addr_t;

	// Four colour indices, byte 0 in bits 7:0
	typedef logic [31:0] vram_word_t;

	// Screen x or y position
	typedef logic [10:0] pixel_pos_t;

	// Palette index
	typedef logic [7:0] color_index_t;

	// Red in 23:16, green in 15:8, blue in 7:0
	typedef logic [23:0] rgb_t;

endpackage

//--- video_controller.f
source/video_types_pkg.sv
source/video_regs_pkg.sv
source/dual_port_ram.sv
source/video_apb_slave.sv
source/line_fetcher.sv
source/pixel_lookup.sv
source/video_controller.sv
sim/video_controller_sva.sv
sim/video_controller_tb.sv
